/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = patch_handler_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: simulate clean

# build, run, then search the output for the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* include/doom_consts.svh */
`ifndef DOOM_CONSTS_SVH
`define DOOM_CONSTS_SVH

// framebuffer geometry in pixels
`define SCREEN_WIDTH  320
`define SCREEN_HEIGHT 200

// topdelta value that closes a column
`define POST_END 8'hff

// slots in the host parameter block
`define PARAM_PATCH_BASE 0
`define PARAM_X          1
`define PARAM_Y          2
`define PARAM_FB_BASE    3

`endif

/* logic/byte_reader.sv */
`timescale 1ns/1ps

module byte_reader (
  input  logic             clk,
  input  logic             reset,
  field_if.server          fields,
  output patch_pkg::addr_t mem_address,
  output logic             mem_read,
  input  logic             mem_waitrequest,
  input  logic [7:0]       mem_readdata
);
  import patch_pkg::*;

  logic [1:0]            count;        // bytes already taken for this field
  logic [1:0]            last_index;   // byte number that completes the field
  logic [23:0]           shift_reg;    // earlier bytes, newest at top
  logic                  byte_done;    // mem beat accepted this cycle
  logic                  last_byte;    // beat is the final one
  logic [FIELD_BITS-1:0] assembled;    // field as seen this cycle

  always_comb begin
    case (fields.size)
      SIZE_BYTE: last_index = 2'd0;
      SIZE_HALF: last_index = 2'd1;
      default:   last_index = 2'd3;   // word
    endcase
  end

  assign mem_address = fields.address + addr_t'(count);   // consecutive bytes
  assign mem_read    = fields.read;                      // count is 0 between fields
  assign byte_done   = mem_read & ~mem_waitrequest;
  assign last_byte   = (count == last_index);

  // current byte on top of the stored ones, then right-align.
  // shift by 8*(3-count) drops the stale low bytes and zero fills
  assign assembled = {mem_readdata, shift_reg} >> {~count, 3'b000};

  assign fields.readdata    = assembled;
  assign fields.waitrequest = fields.read & ~(byte_done & last_byte);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= 2'd0;
    end else if (byte_done) begin
      if (last_byte) begin
        count <= 2'd0;   // ready for next field
      end else begin
        count <= count + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_done) begin
      shift_reg <= {mem_readdata, shift_reg[23:8]};   // little endian, lowest first
    end
  end

endmodule

/* logic/field_if.sv */
`timescale 1ns/1ps

// field request channel between patch walker and byte reader
interface field_if;
  import patch_pkg::*;

  addr_t                 address;       // first byte of field
  field_size_t           size;          // 1, 2 or 4 bytes
  logic                  read;          // held until waitrequest low
  logic                  waitrequest;   // high until last byte arrives
  logic [FIELD_BITS-1:0] readdata;      // valid with read & !waitrequest

  modport requester (
    output address,
    output size,
    output read,
    input  waitrequest,
    input  readdata
  );

  modport server (
    input  address,
    input  size,
    input  read,
    output waitrequest,
    output readdata
  );

endinterface

/* logic/patch_handler.sv */
`timescale 1ns/1ps
`include "doom_consts.svh"

module patch_handler #(
  parameter int FIFO_DEPTH = 4   // writer queue entries
) (
  input  logic             clk,
  input  logic             reset,
  input  patch_pkg::addr_t hps_params [8],
  input  logic             start,
  output logic             processing,
  output logic [6:0]       debug_seg_export,
  output patch_pkg::addr_t mem_address,        // patch memory master
  output logic             mem_read,
  input  logic             mem_waitrequest,
  input  logic [7:0]       mem_readdata,
  output patch_pkg::addr_t vga_address,        // framebuffer master
  output logic             vga_write,
  output logic [15:0]      vga_writedata,
  input  logic             vga_waitrequest
);
  import patch_pkg::*;

  field_if fields ();   // walker to byte reader

  logic   pix_write;         // walker offers a pixel
  pixel_t pix_data;
  logic   pix_waitrequest;   // writer queue full
  logic   walker_busy;
  logic   writer_idle;

  patch_walker u_walker (
    .clk              (clk),
    .reset            (reset),
    .hps_params       (hps_params),
    .start            (start),
    .fields           (fields.requester),
    .pix_write        (pix_write),
    .pix_data         (pix_data),
    .pix_waitrequest  (pix_waitrequest),
    .busy             (walker_busy),
    .debug_seg_export (debug_seg_export)
  );

  byte_reader u_reader (
    .clk             (clk),
    .reset           (reset),
    .fields          (fields.server),
    .mem_address     (mem_address),
    .mem_read        (mem_read),
    .mem_waitrequest (mem_waitrequest),
    .mem_readdata    (mem_readdata)
  );

  pixel_writer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_writer (
    .clk             (clk),
    .reset           (reset),
    .fb_base         (hps_params[`PARAM_FB_BASE]),
    .pix_write       (pix_write),
    .pix_data        (pix_data),
    .pix_waitrequest (pix_waitrequest),
    .vga_address     (vga_address),
    .vga_write       (vga_write),
    .vga_writedata   (vga_writedata),
    .vga_waitrequest (vga_waitrequest),
    .idle            (writer_idle)
  );

  // start shows up at once, tail covers queued writes
  assign processing = walker_busy | ~writer_idle | (start & ~walker_busy);

endmodule

/* logic/patch_pkg.sv */
package patch_pkg;
  `include "doom_consts.svh"

  localparam int ADDR_BITS  = 32;   // avalon byte address
  localparam int COORD_BITS = 16;   // matches doom short
  localparam int FIELD_BITS = 32;   // widest header field, columnofs

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic signed [COORD_BITS-1:0] coord_t;

  // byte count of one little-endian field
  typedef logic [1:0] field_size_t;
  localparam field_size_t SIZE_BYTE = 2'd0;   // topdelta, length, pixel
  localparam field_size_t SIZE_HALF = 2'd1;   // width and offsets
  localparam field_size_t SIZE_WORD = 2'd2;   // columnofs entry

  // one screen pixel on its way to the writer, 40 bits
  typedef struct packed {
    coord_t     x;        // may be off screen
    coord_t     y;        // may be off screen
    logic [7:0] colour;   // raw palette index
  } pixel_t;

  // walker FSM, code also goes to the seven segment debug port
  typedef enum logic [3:0] {
    S_IDLE     = 4'd0,   // waiting for start
    S_WIDTH    = 4'd1,   // header width
    S_LEFTOFS  = 4'd2,   // header leftoffset
    S_TOPOFS   = 4'd3,   // header topoffset
    S_COLOFS   = 4'd4,   // columnofs[col]
    S_TOPDELTA = 4'd5,   // post start row or end marker
    S_LENGTH   = 4'd6,   // post pixel count
    S_PIXEL    = 4'd7,   // fetch one source byte
    S_EMIT     = 4'd8    // hand pixel to writer
  } walker_state_t;

endpackage

/* logic/patch_walker.sv */
`timescale 1ns/1ps
`include "doom_consts.svh"

module patch_walker (
  input  logic              clk,
  input  logic              reset,
  input  patch_pkg::addr_t  hps_params [8],
  input  logic              start,
  field_if.requester        fields,
  output logic              pix_write,
  output patch_pkg::pixel_t pix_data,
  input  logic              pix_waitrequest,
  output logic              busy,
  output logic [6:0]        debug_seg_export
);
  import patch_pkg::*;

  walker_state_t state;
  addr_t         patch_base;   // patch_t in byte memory
  coord_t        scr_x;        // host x before leftoffset
  coord_t        scr_y;        // host y before topoffset
  coord_t        org_x;        // screen x of column 0
  coord_t        org_y;        // screen y of row 0
  logic [15:0]   width;        // column count
  logic [15:0]   col;          // current column
  logic [15:0]   next_col;
  addr_t         post_addr;    // next topdelta byte
  addr_t         src_addr;     // next source pixel byte
  logic [7:0]    count;        // pixels left in post
  coord_t        row;          // screen y of next pixel
  logic [7:0]    colour;       // fetched source byte
  logic          field_done;   // requested field valid this cycle
  logic [15:0]   field_half;
  logic [7:0]    field_byte;

  assign field_done = fields.read & ~fields.waitrequest;
  assign field_half = fields.readdata[15:0];
  assign field_byte = fields.readdata[7:0];
  assign next_col   = col + 16'd1;

  // field request, all from registers so it holds across waitrequest
  always_comb begin
    fields.read    = 1'b1;
    fields.address = post_addr;
    fields.size    = SIZE_BYTE;
    case (state)
      S_IDLE: begin
        fields.read = 1'b0;
      end
      S_WIDTH: begin
        fields.address = patch_base;   // width at +0, height at +2 unused
        fields.size    = SIZE_HALF;
      end
      S_LEFTOFS: begin
        fields.address = patch_base + 32'd4;
        fields.size    = SIZE_HALF;
      end
      S_TOPOFS: begin
        fields.address = patch_base + 32'd6;
        fields.size    = SIZE_HALF;
      end
      S_COLOFS: begin
        fields.address = patch_base + 32'd8 + addr_t'({col, 2'b00});   // columnofs[col]
        fields.size    = SIZE_WORD;
      end
      S_LENGTH: begin
        fields.address = post_addr + 32'd1;
      end
      S_PIXEL: begin
        fields.address = src_addr;
      end
      S_EMIT: begin
        fields.read = 1'b0;   // waiting on writer
      end
      default: begin
        fields.address = post_addr;   // topdelta
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            patch_base <= hps_params[`PARAM_PATCH_BASE];
            scr_x      <= coord_t'(hps_params[`PARAM_X][15:0]);
            scr_y      <= coord_t'(hps_params[`PARAM_Y][15:0]);
            state      <= S_WIDTH;
          end
        end
        S_WIDTH: begin
          if (field_done) begin
            width <= field_half;
            state <= S_LEFTOFS;
          end
        end
        S_LEFTOFS: begin
          if (field_done) begin
            org_x <= scr_x - coord_t'(field_half);   // x -= leftoffset
            state <= S_TOPOFS;
          end
        end
        S_TOPOFS: begin
          if (field_done) begin
            org_y <= scr_y - coord_t'(field_half);   // y -= topoffset
            col   <= 16'd0;
            state <= (width == 16'd0) ? S_IDLE : S_COLOFS;
          end
        end
        S_COLOFS: begin
          if (field_done) begin
            post_addr <= patch_base + addr_t'(fields.readdata);   // offset from patch start
            state     <= S_TOPDELTA;
          end
        end
        S_TOPDELTA: begin
          if (field_done) begin
            if (field_byte == `POST_END) begin
              col   <= next_col;
              state <= (next_col == width) ? S_IDLE : S_COLOFS;
            end else begin
              row   <= org_y + coord_t'({8'h00, field_byte});
              state <= S_LENGTH;
            end
          end
        end
        S_LENGTH: begin
          if (field_done) begin
            count     <= field_byte;
            src_addr  <= post_addr + 32'd3;   // skip topdelta, length, pad
            post_addr <= post_addr + addr_t'(field_byte) + 32'd4;   // following post
            state     <= (field_byte == 8'd0) ? S_TOPDELTA : S_PIXEL;
          end
        end
        S_PIXEL: begin
          if (field_done) begin
            colour <= field_byte;
            state  <= S_EMIT;
          end
        end
        S_EMIT: begin
          if (!pix_waitrequest) begin
            row      <= row + coord_t'(1);   // dest += SCREENWIDTH
            src_addr <= src_addr + 32'd1;
            count    <= count - 8'd1;
            state    <= (count == 8'd1) ? S_TOPDELTA : S_PIXEL;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign pix_write = (state == S_EMIT);

  always_comb begin
    pix_data.x      = org_x + coord_t'(col);
    pix_data.y      = row;
    pix_data.colour = colour;
  end

  assign busy             = (state != S_IDLE);
  assign debug_seg_export = 7'(state);   // raw state code

endmodule

/* logic/pixel_writer.sv */
`timescale 1ns/1ps
`include "doom_consts.svh"

module pixel_writer #(
  parameter int FIFO_DEPTH = 4   // power of two, 2 or more
) (
  input  logic              clk,
  input  logic              reset,
  input  patch_pkg::addr_t  fb_base,
  input  logic              pix_write,
  input  patch_pkg::pixel_t pix_data,
  output logic              pix_waitrequest,
  output patch_pkg::addr_t  vga_address,
  output logic              vga_write,
  output logic [15:0]       vga_writedata,
  input  logic              vga_waitrequest,
  output logic              idle
);
  import patch_pkg::*;

  localparam int PTR_BITS = $clog2(FIFO_DEPTH);

  addr_t               addr_mem   [FIFO_DEPTH];   // framebuffer address per entry
  logic [7:0]          colour_mem [FIFO_DEPTH];   // palette index per entry
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   used;                      // entries held
  logic                full;
  logic                empty;
  logic                on_screen;
  logic                accept;                    // pixel handshake done
  logic                push;
  logic                pop;
  logic [16:0]         pix_index;                 // y * width + x, up to 63999
  addr_t               pix_addr;

  // clip against 0 <= x < width, 0 <= y < height
  assign on_screen = (pix_data.x >= coord_t'(0)) &&
                     (pix_data.x <  coord_t'(`SCREEN_WIDTH)) &&
                     (pix_data.y >= coord_t'(0)) &&
                     (pix_data.y <  coord_t'(`SCREEN_HEIGHT));

  // bounds above keep x to 9 bits and y to 8 bits
  assign pix_index = 17'(pix_data.y[7:0]) * 17'(`SCREEN_WIDTH) + 17'(pix_data.x[8:0]);
  assign pix_addr  = fb_base + addr_t'({pix_index, 1'b0});   // 16-bit pixels

  assign full            = (used == (PTR_BITS+1)'(FIFO_DEPTH));
  assign empty           = (used == '0);
  assign pix_waitrequest = full;
  assign accept          = pix_write & ~full;
  assign push            = accept & on_screen;   // off-screen ones vanish here
  assign pop             = vga_write & ~vga_waitrequest;

  // head stays on the bus until taken
  assign vga_write     = ~empty;
  assign vga_address   = addr_mem[rd_ptr];
  assign vga_writedata = {8'h00, colour_mem[rd_ptr]};   // zero-extended index
  assign idle          = empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;   // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr]   <= pix_addr;
      colour_mem[wr_ptr] <= pix_data.colour;
    end
  end

endmodule

/* testbench/patch_handler_checker.sv */
`timescale 1ns/1ps
`include "doom_consts.svh"

module patch_handler_checker (
  input logic              clk,
  input logic              reset,
  input patch_pkg::addr_t  fb_base,
  input logic              processing,
  input patch_pkg::addr_t  mem_address,
  input logic              mem_read,
  input logic              mem_waitrequest,
  input patch_pkg::addr_t  vga_address,
  input logic              vga_write,
  input logic [15:0]       vga_writedata,
  input logic              vga_waitrequest
);
  import patch_pkg::*;

  localparam addr_t FB_BYTES = addr_t'(2 * `SCREEN_WIDTH * `SCREEN_HEIGHT);   // 16-bit pixels

  // read command held until the slave takes it
  mem_hold: assert property (@(posedge clk) disable iff (reset)
    mem_read && mem_waitrequest |=> mem_read && $stable(mem_address))
    else $error("mem read dropped or moved while waitrequest was high");

  vga_hold: assert property (@(posedge clk) disable iff (reset)
    vga_write && vga_waitrequest |=> vga_write && $stable(vga_address) &&
                                     $stable(vga_writedata))
    else $error("vga write dropped or changed while waitrequest was high");

  // wraps below base, so one compare covers both ends
  fb_range: assert property (@(posedge clk) disable iff (reset)
    vga_write |-> (vga_address - fb_base) < FB_BYTES)
    else $error("vga write outside the framebuffer");

  reset_quiet: assert property (@(posedge clk)
    $fell(reset) |-> !processing && !mem_read && !vga_write)
    else $error("bus or processing active right after reset");

endmodule

bind patch_handler patch_handler_checker u_checker (
  .clk             (clk),
  .reset           (reset),
  .fb_base         (hps_params[`PARAM_FB_BASE]),
  .processing      (processing),
  .mem_address     (mem_address),
  .mem_read        (mem_read),
  .mem_waitrequest (mem_waitrequest),
  .vga_address     (vga_address),
  .vga_write       (vga_write),
  .vga_writedata   (vga_writedata),
  .vga_waitrequest (vga_waitrequest)
);

/* testbench/patch_handler_tb.sv */
`timescale 1ns/1ps
`include "doom_consts.svh"

module patch_handler_tb;
  import patch_pkg::*;

  localparam int          CLK_PERIOD = 8;
  localparam int          MEM_SIZE   = 65536;
  localparam int          FB_PIXELS  = `SCREEN_WIDTH * `SCREEN_HEIGHT;
  localparam logic [31:0] FB_BASE    = 32'h0010_0000;
  localparam logic [15:0] SENTINEL   = 16'hdead;   // never a zero-extended colour
  // draws below: width * posts * length each
  localparam int TOTAL_PIXELS  = 8*10 + 10*3*4 + 12*2*6 + 330*2*6 + 16*2*20 + 20*30;
  localparam int TOTAL_COLUMNS = 8 + 10 + 12 + 330 + 16 + 20;
  localparam int STRETCH_BOUND = 40;   // cycles per pixel under heavy waitrequest
  localparam int LIMIT_CYCLES  = (TOTAL_PIXELS + 8 * TOTAL_COLUMNS) * STRETCH_BOUND + 2000;

  logic        clk;
  logic        reset;
  logic        start;
  logic        processing;
  addr_t       hps_params [8];
  logic [6:0]  debug_seg_export;
  addr_t       mem_address;
  logic        mem_read;
  logic        mem_waitrequest;
  logic [7:0]  mem_readdata;
  addr_t       vga_address;
  logic        vga_write;
  logic [15:0] vga_writedata;
  logic        vga_waitrequest;

  logic [7:0]  mem    [MEM_SIZE];    // patch bytes
  logic [15:0] fb     [FB_PIXELS];   // what the DUT wrote
  logic [15:0] exp_fb [FB_PIXELS];   // reference draw
  int          wait_pct;             // waitrequest chance in percent
  int          mem_reads;
  int          vga_writes;
  logic        compare_go;           // main -> compare process

  patch_handler uut (
    .clk              (clk),
    .reset            (reset),
    .hps_params       (hps_params),
    .start            (start),
    .processing       (processing),
    .debug_seg_export (debug_seg_export),
    .mem_address      (mem_address),
    .mem_read         (mem_read),
    .mem_waitrequest  (mem_waitrequest),
    .mem_readdata     (mem_readdata),
    .vga_address      (vga_address),
    .vga_write        (vga_write),
    .vga_writedata    (vga_writedata),
    .vga_waitrequest  (vga_waitrequest)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  // slave side of both buses, new values each falling edge
  always @(negedge clk) begin
    mem_waitrequest = ($urandom_range(99) < wait_pct);
    vga_waitrequest = ($urandom_range(99) < wait_pct);
    mem_readdata    = mem[mem_address[15:0]];   // address steady since rising edge
  end

  // accepted beats, taken at the edge that completes them
  always @(posedge clk) begin
    if (!reset && mem_read && !mem_waitrequest) begin
      mem_reads++;
    end
    if (!reset && vga_write && !vga_waitrequest) begin
      vga_writes++;
      if ((vga_address - FB_BASE) >= 32'(2 * FB_PIXELS) || vga_address[0]) begin
        abort_run($sformatf("vga write to 0x%h is not a framebuffer pixel", vga_address));
      end else begin
        fb[int'((vga_address - FB_BASE) >> 1)] = vga_writedata;
      end
    end
  end

  task automatic put_bytes(input int addr, input int value, input int count);
    for (int k = 0; k < count; k++) begin
      mem[addr + k] = 8'(value >> (8 * k));   // little endian
    end
  endtask

  function automatic int get_bytes(input int addr, input int count);
    int value;
    value = 0;
    for (int k = 0; k < count; k++) begin
      value = value | (int'(mem[addr + k]) << (8 * k));
    end
    return value;
  endfunction

  function automatic int get_short(input int addr);
    logic [15:0] half;
    half = 16'(get_bytes(addr, 2));
    return int'($signed(half));   // header offsets are signed
  endfunction

  // posts per column, topdelta staggered by column
  task automatic build_patch(input int base, input int width, input int leftofs,
                             input int topofs, input int posts, input int len, input int gap);
    int ptr;
    ptr = 8 + 4 * width;   // column data after offset table
    put_bytes(base, width, 2);
    put_bytes(base + 2, posts * (len + gap) + 2, 2);   // height, unused by blitter
    put_bytes(base + 4, leftofs, 2);
    put_bytes(base + 6, topofs, 2);
    for (int c = 0; c < width; c++) begin
      put_bytes(base + 8 + 4 * c, ptr, 4);
      for (int p = 0; p < posts; p++) begin
        mem[base + ptr]     = 8'(p * (len + gap) + c % 3);
        mem[base + ptr + 1] = 8'(len);
        mem[base + ptr + 2] = 8'h00;   // pad
        for (int i = 0; i < len; i++) begin
          mem[base + ptr + 3 + i] = 8'($urandom);
        end
        mem[base + ptr + 3 + len] = 8'h00;
        ptr += len + 4;
      end
      mem[base + ptr] = `POST_END;
      ptr++;
    end
  endtask

  // V_DrawPatch onto exp_fb, clipped to the screen
  function automatic void draw_patch(input int base, input int x, input int y);
    int width;
    int post;
    int len;
    int sx;
    int sy;
    width = get_bytes(base, 2);
    x     = x - get_short(base + 4);
    y     = y - get_short(base + 6);
    for (int c = 0; c < width; c++) begin
      post = base + get_bytes(base + 8 + 4 * c, 4);
      while (mem[post] != `POST_END) begin
        len = int'(mem[post + 1]);
        for (int i = 0; i < len; i++) begin
          sx = x + c;
          sy = y + int'(mem[post]) + i;
          if (sx >= 0 && sx < `SCREEN_WIDTH && sy >= 0 && sy < `SCREEN_HEIGHT) begin
            exp_fb[sy * `SCREEN_WIDTH + sx] = {8'h00, mem[post + 3 + i]};
          end
        end
        post += len + 4;
      end
    end
  endfunction

  task automatic clear_frames();
    for (int i = 0; i < FB_PIXELS; i++) begin
      fb[i]     = SENTINEL;
      exp_fb[i] = SENTINEL;
    end
  endtask

  // one start pulse, then wait for processing to drop
  task automatic draw_on_dut(input int base, input int x, input int y);
    @(negedge clk);
    check_value("processing", 32'(processing), 32'd0);
    hps_params[`PARAM_PATCH_BASE] = addr_t'(base);
    hps_params[`PARAM_X]          = addr_t'(x);
    hps_params[`PARAM_Y]          = addr_t'(y);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value("processing", 32'(processing), 32'd1);
    check_value("debug_seg_export", 32'(debug_seg_export), 32'(S_WIDTH));   // header first
    while (processing) begin
      @(negedge clk);
    end
    check_value("debug_seg_export", 32'(debug_seg_export), 32'(S_IDLE));
    draw_patch(base, x, y);
  endtask

  task automatic compare_frames();
    compare_go = 1'b1;
    wait (!compare_go);
  endtask

  // scans the whole screen on request
  initial begin
    forever begin
      wait (compare_go);
      for (int i = 0; i < FB_PIXELS; i++) begin
        check_value($sformatf("vga_writedata at fb[%0d]", i), 32'(fb[i]), 32'(exp_fb[i]));
      end
      compare_go = 1'b0;
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    abort_run($sformatf("timeout, drawing did not finish within %0d cycles", LIMIT_CYCLES));
  end

  initial begin
    void'($urandom(28723));
    reset           = 1'b1;
    start           = 1'b0;
    mem_waitrequest = 1'b1;
    vga_waitrequest = 1'b1;
    mem_readdata    = 8'h00;
    wait_pct        = 30;
    mem_reads       = 0;
    vga_writes      = 0;
    compare_go      = 1'b0;
    for (int i = 0; i < 8; i++) begin
      hps_params[i] = '0;
    end
    hps_params[`PARAM_FB_BASE] = FB_BASE;
    for (int a = 0; a < MEM_SIZE; a++) begin
      mem[a] = 8'(a ^ (a >> 8) ^ 8'h5a);   // junk where no patch sits
    end
    clear_frames();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle after reset
    repeat (10) begin
      @(negedge clk);
      check_value("processing", 32'(processing), 32'd0);
      check_value("debug_seg_export", 32'(debug_seg_export), 32'(S_IDLE));
    end
    check_value("mem_read beats", 32'(mem_reads), 32'd0);
    check_value("vga_write beats", 32'(vga_writes), 32'd0);

    build_patch(32'h0100, 8, 0, 0, 1, 10, 0);   // single post, centre
    draw_on_dut(32'h0100, 150, 90);
    compare_frames();

    clear_frames();
    build_patch(32'h0400, 10, 0, 0, 3, 4, 3);   // gapped posts
    draw_on_dut(32'h0400, 60, 120);
    compare_frames();

    clear_frames();
    build_patch(32'h0800, 12, 5, -3, 2, 6, 2);   // shifted origin
    draw_on_dut(32'h0800, 40, 30);
    compare_frames();

    clear_frames();
    build_patch(32'h1000, 330, 0, 0, 2, 6, 194);   // wider and taller than screen
    draw_on_dut(32'h1000, -5, -3);
    compare_frames();

    // back to back under heavy stall
    clear_frames();
    wait_pct = 75;
    build_patch(32'h4000, 16, 2, 2, 2, 20, 5);
    build_patch(32'h5000, 20, 0, -4, 1, 30, 0);
    draw_on_dut(32'h4000, 100, 50);
    repeat (4) begin
      @(negedge clk);
      check_value("processing", 32'(processing), 32'd0);
    end
    draw_on_dut(32'h5000, 105, 60);
    compare_frames();

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
logic/patch_pkg.sv
logic/field_if.sv
logic/byte_reader.sv
logic/patch_walker.sv
logic/pixel_writer.sv
logic/patch_handler.sv
testbench/patch_handler_checker.sv
testbench/patch_handler_tb.sv
